// ==== sources.f ====
source/mem_pkg.sv
source/line_port_if.sv
source/ifetch_line_buffer.sv
source/data_req_latch.sv
source/mem_arbiter.sv
source/burst_adapter.sv
source/mem_top.sv
tb/bmem_model.sv
tb/tb_mem_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_mem_top \
    -f sources.f -o tb_mem_top_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_mem_top_sim > sim.log 2>&1
grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/tb_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_top;
    import mem_pkg::*;

    localparam logic [31:0] PATTERN = 32'h5a5a_0000;
    localparam logic [31:0] SEED    = 32'ha66d_c4ed;
    localparam int          TIMEOUT = 2000;     // cycles per wait

    logic   clk;
    logic   rst;
    logic   fetch_read_i;
    addr_t  fetch_addr_i;
    word_t  fetch_word_o;
    logic   fetch_resp_o;
    logic   data_read_i;
    logic   data_write_i;
    addr_t  data_addr_i;
    line_t  data_wdata_i;
    line_t  data_rdata_o;
    logic   data_resp_o;
    addr_t  bmem_addr_o;
    logic   bmem_read_o;
    logic   bmem_write_o;
    beat_t  bmem_wdata_o;
    logic   bmem_ready_i;
    beat_t  bmem_rdata_i;
    logic   bmem_rvalid_i;

    logic   [31:0]  rng;
    logic           strobe_seen;    // any request driven since reset
    addr_t          read_log [$];   // address of every read burst

    mem_top mem_top_i (.*);

    bmem_model #(
        .SEED       (SEED),
        .PATTERN    (PATTERN)
    ) mem_model_i (
        .clk            (clk),
        .bmem_addr_i    (bmem_addr_o),
        .bmem_read_i    (bmem_read_o),
        .bmem_write_i   (bmem_write_o),
        .bmem_wdata_i   (bmem_wdata_o),
        .bmem_ready_o   (bmem_ready_i),
        .bmem_rdata_o   (bmem_rdata_i),
        .bmem_rvalid_o  (bmem_rvalid_i)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (!rst && bmem_read_o)
            read_log.push_back(bmem_addr_o);
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string test, input line_t expected, input line_t actual);
        assert (expected == actual)
        else abort_run($sformatf("error %s: expected %h, actual %h", test, expected, actual));
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // each word starts out holding its own byte address xor the pattern
    function automatic word_t rule_word(input addr_t a);
        return {a[31:2], 2'b00} ^ PATTERN;
    endfunction

    function automatic line_t rule_line(input addr_t a);
        line_t  l;
        addr_t  base;
        int     k;
        base = {a[31:5], 5'b0};
        for (k = 0; k < 8; k++)
            l[k*32 +: 32] = (base + addr_t'(4 * k)) ^ PATTERN;
        return l;
    endfunction

    task automatic make_random_line(output line_t l);
        int k;
        for (k = 0; k < 8; k++) begin
            rng = lcg_next(rng);
            l[k*32 +: 32] = rng;
        end
    endtask

    task automatic fetch_strobe(input addr_t a);
        @(negedge clk);
        fetch_read_i = 1'b1;
        fetch_addr_i = a;
        strobe_seen  = 1'b1;
        @(negedge clk);
        fetch_read_i = 1'b0;
    endtask

    task automatic data_strobe(input logic write, input addr_t a, input line_t d);
        @(negedge clk);
        data_read_i  = !write;
        data_write_i = write;
        data_addr_i  = a;
        data_wdata_i = d;
        strobe_seen  = 1'b1;
        @(negedge clk);
        data_read_i  = 1'b0;
        data_write_i = 1'b0;
    endtask

    task automatic read_and_fetch(input addr_t da, input addr_t fa);
        @(negedge clk);
        data_read_i  = 1'b1;
        data_addr_i  = da;
        fetch_read_i = 1'b1;
        fetch_addr_i = fa;
        strobe_seen  = 1'b1;
        @(negedge clk);
        data_read_i  = 1'b0;
        fetch_read_i = 1'b0;
    endtask

    task automatic wait_fetch(output word_t word);
        int n;
        n = 0;
        while (!fetch_resp_o) begin
            if (n == TIMEOUT)
                abort_run("timeout waiting for a fetch response");
            n++;
            @(negedge clk);
        end
        word = fetch_word_o;
    endtask

    task automatic wait_data(output line_t line);
        int n;
        n = 0;
        while (!data_resp_o) begin
            if (n == TIMEOUT)
                abort_run("timeout waiting for a data response");
            n++;
            @(negedge clk);
        end
        line = data_rdata_o;
    endtask

    // the two pulses come at different times so catch each one
    task automatic wait_both(output word_t word, output line_t line);
        int     n;
        logic   got_f;
        logic   got_d;
        n     = 0;
        got_f = 1'b0;
        got_d = 1'b0;
        while (!(got_f && got_d)) begin
            if (fetch_resp_o) begin
                got_f = 1'b1;
                word  = fetch_word_o;
            end
            if (data_resp_o) begin
                got_d = 1'b1;
                line  = data_rdata_o;
            end
            if (!(got_f && got_d)) begin
                if (n == TIMEOUT)
                    abort_run("timeout waiting for the fetch and data responses");
                n++;
                @(negedge clk);
            end
        end
    endtask

    // quiet outputs until the first request
    assert property (@(posedge clk) disable iff (rst)
        !strobe_seen |-> !(fetch_resp_o || data_resp_o || bmem_read_o || bmem_write_o))
    else abort_run("response or memory activity seen before any request");

    assert property (@(posedge clk) disable iff (rst) bmem_read_o |-> bmem_ready_i)
    else abort_run("read burst started while memory was not ready");

    assert property (@(posedge clk) disable iff (rst)
        (bmem_write_o && !$past(bmem_write_o)) |-> bmem_ready_i)
    else abort_run("write burst started while memory was not ready");

    initial begin
        word_t  word;
        line_t  line;
        line_t  wline;
        addr_t  a;
        int     mark;
        int     i;

        clk          = 1'b0;
        rst          = 1'b1;
        fetch_read_i = 1'b0;
        fetch_addr_i = '0;
        data_read_i  = 1'b0;
        data_write_i = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        strobe_seen  = 1'b0;
        rng          = SEED;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (8) @(negedge clk);     // idle stretch after reset

        // cold fetch misses the buffer
        a = 32'h0000_1064;
        fetch_strobe(a);
        wait_fetch(word);
        check_equal("fetch miss", line_t'(rule_word(a)), line_t'(word));

        // hits in the same line answer one cycle later without memory
        mark = read_log.size();
        for (i = 0; i < 3; i++) begin
            rng = lcg_next(rng);
            a = {27'h0000_083, rng[4:2], 2'b00};
            fetch_strobe(a);
            assert (fetch_resp_o)
            else abort_run("fetch hit did not respond on the next cycle");
            check_equal("fetch hit", line_t'(rule_word(a)), line_t'(fetch_word_o));
        end

        // write a random line and read it back
        for (i = 0; i < 2; i++) begin
            a = 32'h0000_2400 + addr_t'(i * 64);
            make_random_line(wline);
            data_strobe(1'b1, a, wline);
            wait_data(line);
            data_strobe(1'b0, a, '0);
            wait_data(line);
            check_equal("data write then read", wline, line);
        end

        // a burst for the hit line would have been granted between the data accesses
        for (i = mark; i < read_log.size(); i++) begin
            assert (read_log[i] != 32'h0000_1060)
            else abort_run("fetch hit started a memory read");
        end

        // data read and fetch miss together with data going to memory first
        mark = read_log.size();
        read_and_fetch(32'h0000_3a40, 32'h0000_5128);
        wait_both(word, line);
        check_equal("joint fetch", line_t'(rule_word(32'h0000_5128)), line_t'(word));
        check_equal("joint data read", rule_line(32'h0000_3a40), line);
        assert (read_log.size() == mark + 2)
        else abort_run("joint requests did not issue exactly two read bursts");
        check_equal("first read address", line_t'(32'h0000_3a40), line_t'(read_log[mark]));

        repeat (5) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule : tb_mem_top

`default_nettype wire

// ==== tb/bmem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module bmem_model #(
    parameter logic [31:0] SEED    = 32'h1,
    parameter logic [31:0] PATTERN = 32'h0
) (
    input   logic               clk,
    input   mem_pkg::addr_t     bmem_addr_i,
    input   logic               bmem_read_i,
    input   logic               bmem_write_i,
    input   mem_pkg::beat_t     bmem_wdata_i,
    output  logic               bmem_ready_o,
    output  mem_pkg::beat_t     bmem_rdata_o,
    output  logic               bmem_rvalid_o
);
    import mem_pkg::*;

    beat_t          stored [addr_t];    // written beats by byte address
    logic   [31:0]  rng = SEED;
    addr_t          rd_addr = '0;
    int             reads_issued = 0;   // bumped on each read pulse
    int             reads_done = 0;     // bumped when the last beat goes out
    int             rd_idx = 0;
    int             wr_idx = 0;
    logic   [2:0]   ready_left = 3'd0;
    logic           ready_q = 1'b0;
    logic           rvalid_q = 1'b0;
    beat_t          rdata_q = '0;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // stored beat if written, else the fill rule (upper word first)
    function automatic beat_t beat_at(input addr_t a);
        if (stored.exists(a))
            return stored[a];
        return {(a + 32'd4) ^ PATTERN, a ^ PATTERN};
    endfunction

    // requests are sampled where the DUT outputs are settled
    always @(posedge clk) begin
        if (bmem_read_i) begin
            rd_addr      <= bmem_addr_i;
            reads_issued <= reads_issued + 1;
        end
        if (bmem_write_i) begin
            stored[bmem_addr_i + addr_t'(wr_idx * 8)] = bmem_wdata_i;
            wr_idx <= (wr_idx == BEATS_PER_LINE - 1) ? 0 : wr_idx + 1;
        end
    end

    // responses change on the falling edge
    always @(negedge clk) begin
        rng = lcg_next(rng);
        if (ready_left == 3'd0) begin
            ready_q    <= (rng[7:6] != 2'b00);  // low roughly a quarter of the time
            ready_left <= {1'b0, rng[9:8]};
        end else begin
            ready_left <= ready_left - 3'd1;
        end

        rvalid_q <= 1'b0;
        if (reads_issued != reads_done && rng[17:16] != 2'b00) begin   // random gaps
            rvalid_q <= 1'b1;
            rdata_q  <= beat_at(rd_addr + addr_t'(rd_idx * 8));
            if (rd_idx == BEATS_PER_LINE - 1) begin
                rd_idx     <= 0;
                reads_done <= reads_done + 1;
            end else begin
                rd_idx <= rd_idx + 1;
            end
        end
    end

    assign bmem_ready_o  = ready_q;
    assign bmem_rvalid_o = rvalid_q;
    assign bmem_rdata_o  = rdata_q;

endmodule : bmem_model

`default_nettype wire

// ==== source/mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_top (
    input   logic               clk,
    input   logic               rst,

    // instruction fetch
    input   logic               fetch_read_i,
    input   mem_pkg::addr_t     fetch_addr_i,
    output  mem_pkg::word_t     fetch_word_o,
    output  logic               fetch_resp_o,

    // data lines
    input   logic               data_read_i,
    input   logic               data_write_i,
    input   mem_pkg::addr_t     data_addr_i,
    input   mem_pkg::line_t     data_wdata_i,
    output  mem_pkg::line_t     data_rdata_o,
    output  logic               data_resp_o,

    // burst memory
    output  mem_pkg::addr_t     bmem_addr_o,
    output  logic               bmem_read_o,
    output  logic               bmem_write_o,
    output  mem_pkg::beat_t     bmem_wdata_o,
    input   logic               bmem_ready_i,
    input   mem_pkg::beat_t     bmem_rdata_i,
    input   logic               bmem_rvalid_i
);
    import mem_pkg::*;

    logic       f_req, f_resp;
    addr_t      f_addr;
    line_t      f_line;

    logic       d_pending, d_resp;
    addr_t      d_addr;
    line_op_e   d_op;
    line_t      d_wdata, d_line;

    line_port_if mem_port_if ();

    ifetch_line_buffer ifetch_i (
        .clk            (clk),
        .rst            (rst),
        .fetch_read_i   (fetch_read_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_word_o   (fetch_word_o),
        .fetch_resp_o   (fetch_resp_o),
        .f_req_o        (f_req),
        .f_addr_o       (f_addr),
        .f_resp_i       (f_resp),
        .f_line_i       (f_line)
    );

    data_req_latch data_i (
        .clk            (clk),
        .rst            (rst),
        .data_read_i    (data_read_i),
        .data_write_i   (data_write_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_rdata_o   (data_rdata_o),
        .data_resp_o    (data_resp_o),
        .d_pending_o    (d_pending),
        .d_addr_o       (d_addr),
        .d_op_o         (d_op),
        .d_wdata_o      (d_wdata),
        .d_resp_i       (d_resp),
        .d_line_i       (d_line)
    );

    mem_arbiter arbiter_i (
        .clk            (clk),
        .rst            (rst),
        .f_req_i        (f_req),
        .f_addr_i       (f_addr),
        .f_resp_o       (f_resp),
        .f_line_o       (f_line),
        .d_pending_i    (d_pending),
        .d_addr_i       (d_addr),
        .d_op_i         (d_op),
        .d_wdata_i      (d_wdata),
        .d_resp_o       (d_resp),
        .d_line_o       (d_line),
        .mem_port       (mem_port_if.requester)
    );

    burst_adapter #(
        .BURST_LEN      (BEATS_PER_LINE)
    ) adapter_i (
        .clk            (clk),
        .rst            (rst),
        .mem_port       (mem_port_if.memside),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i)
    );

endmodule : mem_top

`default_nettype wire

// ==== source/burst_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_adapter #(
    parameter int BURST_LEN = 4
) (
    input   logic               clk,
    input   logic               rst,

    line_port_if.memside        mem_port,

    output  mem_pkg::addr_t     bmem_addr_o,
    output  logic               bmem_read_o,
    output  logic               bmem_write_o,
    output  mem_pkg::beat_t     bmem_wdata_o,
    input   logic               bmem_ready_i,
    input   mem_pkg::beat_t     bmem_rdata_i,
    input   logic               bmem_rvalid_i
);
    import mem_pkg::*;

    localparam int CNT_BITS = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

    addr_t                  addr_q;
    line_op_e               op_q;
    line_t                  line_q;     // write beats out of the bottom, read beats in at the top
    logic                   waiting;    // request taken, burst not started yet
    logic                   rd_busy;
    logic                   wr_busy;
    logic   [CNT_BITS-1:0]  cnt;
    logic                   last;
    logic                   resp_q;
    logic                   rd_start;
    logic                   wr_start;

    assign rd_start = waiting && (op_q == op_read) && bmem_ready_i;
    assign wr_start = waiting && (op_q == op_write) && bmem_ready_i;
    assign last     = (cnt == CNT_BITS'(BURST_LEN - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting <= 1'b0;
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            cnt     <= '0;
            resp_q  <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            if (mem_port.req)
                waiting <= 1'b1;
            else if (rd_start || wr_start)
                waiting <= 1'b0;

            if (rd_start)
                rd_busy <= 1'b1;

            if (rd_busy && bmem_rvalid_i) begin
                if (last) begin
                    rd_busy <= 1'b0;
                    cnt     <= '0;
                    resp_q  <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end

            if (bmem_write_o) begin
                if (last) begin
                    wr_busy <= 1'b0;
                    cnt     <= '0;
                    resp_q  <= 1'b1;
                end else begin
                    wr_busy <= 1'b1;
                    cnt     <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_port.req) begin
            addr_q <= mem_port.addr;
            op_q   <= mem_port.op;
            line_q <= mem_port.wdata;
        end else if (bmem_write_o) begin
            line_q <= line_q >> BEAT_BITS;
        end else if (rd_busy && bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

    assign bmem_addr_o    = addr_q;
    assign bmem_read_o    = rd_start;               // single cycle pulse
    assign bmem_write_o   = wr_start || wr_busy;    // back to back beats
    assign bmem_wdata_o   = line_q[BEAT_BITS-1:0];
    assign mem_port.rdata = line_q;
    assign mem_port.resp  = resp_q;

    // memory returns beats only for a read burst we issued
    assert property (@(posedge clk) disable iff (rst) bmem_rvalid_i |-> rd_busy);

endmodule : burst_adapter

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input   logic                   clk,
    input   logic                   rst,

    // fetch side
    input   logic                   f_req_i,
    input   mem_pkg::addr_t         f_addr_i,
    output  logic                   f_resp_o,
    output  mem_pkg::line_t         f_line_o,

    // data side
    input   logic                   d_pending_i,
    input   mem_pkg::addr_t         d_addr_i,
    input   mem_pkg::line_op_e      d_op_i,
    input   mem_pkg::line_t         d_wdata_i,
    output  logic                   d_resp_o,
    output  mem_pkg::line_t         d_line_o,

    line_port_if.requester          mem_port
);
    import mem_pkg::*;

    arb_state_e state;
    logic       f_pend;     // fetch pulse waiting for a grant
    logic       req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= arb_idle;
            f_pend <= 1'b0;
            req_q  <= 1'b0;
        end else begin
            req_q <= 1'b0;
            if (f_req_i)
                f_pend <= 1'b1;
            else if (f_resp_o)
                f_pend <= 1'b0;

            case (state)
                arb_idle: begin
                    if (d_pending_i) begin      // data wins a tie
                        state <= arb_data;
                        req_q <= 1'b1;
                    end else if (f_pend) begin
                        state <= arb_fetch;
                        req_q <= 1'b1;
                    end
                end
                arb_data, arb_fetch: begin
                    if (mem_port.resp)
                        state <= arb_idle;
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // request fields follow the grant
    always_comb begin
        mem_port.req   = req_q;
        mem_port.wdata = d_wdata_i;
        if (state == arb_fetch) begin
            mem_port.addr = f_addr_i;
            mem_port.op   = op_read;
        end else begin
            mem_port.addr = d_addr_i;
            mem_port.op   = d_op_i;
        end
    end

    assign f_resp_o = (state == arb_fetch) && mem_port.resp;
    assign d_resp_o = (state == arb_data) && mem_port.resp;
    assign f_line_o = mem_port.rdata;
    assign d_line_o = mem_port.rdata;

    // adapter only answers a granted request
    assert property (@(posedge clk) disable iff (rst) mem_port.resp |-> state != arb_idle);

endmodule : mem_arbiter

`default_nettype wire

// ==== source/data_req_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_req_latch (
    input   logic                   clk,
    input   logic                   rst,

    input   logic                   data_read_i,
    input   logic                   data_write_i,
    input   mem_pkg::addr_t         data_addr_i,
    input   mem_pkg::line_t         data_wdata_i,
    output  mem_pkg::line_t         data_rdata_o,
    output  logic                   data_resp_o,

    output  logic                   d_pending_o,
    output  mem_pkg::addr_t         d_addr_o,
    output  mem_pkg::line_op_e      d_op_o,
    output  mem_pkg::line_t         d_wdata_o,
    input   logic                   d_resp_i,
    input   mem_pkg::line_t         d_line_i
);
    import mem_pkg::*;

    logic       pending_q;
    logic       resp_q;
    addr_t      addr_q;
    line_op_e   op_q;
    line_t      wdata_q;
    line_t      rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
            resp_q    <= 1'b0;
        end else begin
            resp_q <= pending_q && d_resp_i;
            if (data_read_i || data_write_i)
                pending_q <= 1'b1;
            else if (d_resp_i)
                pending_q <= 1'b0;  // held until the line comes back
        end
    end

    always_ff @(posedge clk) begin
        if (data_read_i || data_write_i) begin
            addr_q  <= data_addr_i & ~addr_t'(LINE_BITS / 8 - 1);  // align to the line
            op_q    <= data_write_i ? op_write : op_read;
            wdata_q <= data_wdata_i;
        end
        if (pending_q && d_resp_i)
            rdata_q <= d_line_i;
    end

    assign d_pending_o  = pending_q;
    assign d_addr_o     = addr_q;
    assign d_op_o       = op_q;
    assign d_wdata_o    = wdata_q;
    assign data_rdata_o = rdata_q;
    assign data_resp_o  = resp_q;

    // one strobe at a time, and none while one is open
    assert property (@(posedge clk) disable iff (rst)
        (data_read_i || data_write_i) |-> !(data_read_i && data_write_i) && !pending_q);

endmodule : data_req_latch

`default_nettype wire

// ==== source/ifetch_line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifetch_line_buffer (
    input   logic               clk,
    input   logic               rst,

    input   logic               fetch_read_i,
    input   mem_pkg::addr_t     fetch_addr_i,
    output  mem_pkg::word_t     fetch_word_o,
    output  logic               fetch_resp_o,

    output  logic               f_req_o,
    output  mem_pkg::addr_t     f_addr_o,
    input   logic               f_resp_i,
    input   mem_pkg::line_t     f_line_i
);
    import mem_pkg::*;

    localparam int OFF_BITS  = $clog2(LINE_BITS / 8);
    localparam int WSEL_BITS = $clog2(LINE_BITS / 32);

    line_t                  buf_line;
    logic   [31-OFF_BITS:0] buf_tag;
    logic                   buf_valid;
    logic   [WSEL_BITS-1:0] word_off;   // word asked for by the last fetch
    logic                   miss_pending;
    logic                   f_req_q;
    logic                   resp_q;
    logic                   hit;

    assign hit = buf_valid && (fetch_addr_i[31:OFF_BITS] == buf_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid    <= 1'b0;
            miss_pending <= 1'b0;
            f_req_q      <= 1'b0;
            resp_q       <= 1'b0;
        end else begin
            f_req_q <= fetch_read_i && !hit;
            resp_q  <= (fetch_read_i && hit) || (miss_pending && f_resp_i);
            if (fetch_read_i && !hit) begin
                buf_valid    <= 1'b0;   // old line gets replaced
                miss_pending <= 1'b1;
            end else if (miss_pending && f_resp_i) begin
                buf_valid    <= 1'b1;
                miss_pending <= 1'b0;
            end
        end
    end

    // line storage, tag and offset
    always_ff @(posedge clk) begin
        if (fetch_read_i) begin
            word_off <= fetch_addr_i[OFF_BITS-1:2];
            if (!hit)
                buf_tag <= fetch_addr_i[31:OFF_BITS];
        end
        if (miss_pending && f_resp_i)
            buf_line <= f_line_i;
    end

    assign f_req_o      = f_req_q;
    assign f_addr_o     = {buf_tag, {OFF_BITS{1'b0}}};
    assign fetch_resp_o = resp_q;
    assign fetch_word_o = buf_line[word_off * 32 +: 32];

    // client keeps a single fetch outstanding
    assert property (@(posedge clk) disable iff (rst) miss_pending |-> !fetch_read_i);

endmodule : ifetch_line_buffer

`default_nettype wire

// ==== source/line_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one line transfer between the arbiter and the burst adapter
interface line_port_if;
    import mem_pkg::*;

    addr_t      addr;   // line aligned
    line_op_e   op;
    logic       req;    // one cycle strobe
    line_t      wdata;
    line_t      rdata;  // valid with resp on reads
    logic       resp;   // exactly one per req

    modport requester (
        output  addr,
        output  op,
        output  req,
        output  wdata,
        input   rdata,
        input   resp
    );

    modport memside (
        input   addr,
        input   op,
        input   req,
        input   wdata,
        output  rdata,
        output  resp
    );

endinterface : line_port_if

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int LINE_BITS      = 256;
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = LINE_BITS / BEAT_BITS;

    typedef logic [31:0]            addr_t;     // byte address
    typedef logic [31:0]            word_t;     // one instruction
    typedef logic [BEAT_BITS-1:0]   beat_t;
    typedef logic [LINE_BITS-1:0]   line_t;

    // what a line request does
    typedef enum logic {
        op_read,
        op_write
    } line_op_e;

    // who owns the shared line port
    typedef enum logic [1:0] {
        arb_idle,
        arb_data,
        arb_fetch
    } arb_state_e;

endpackage : mem_pkg

`default_nettype wire
